// File: hw/mem_msg_defines.svh
`ifndef MEM_MSG_DEFINES_SVH
`define MEM_MSG_DEFINES_SVH

// ========================================
// Message widths
`define MEM_DATA_W      32
`define MEM_ADDR_W      16
`define MEM_ID_W        4

// ========================================
// Address map
`define MEM_REGION_BIT  15     // Set selects the I/O region
`define DRAM_WORDS      64
`define DRAM_IDX_W      6
`define IO_REGS         8
`define IO_REG_IDX_W    3
`define IO_DEV_W        4
`define IO_DEV_ID       4'h5   // Device id this register bank answers to

`endif

// File: hw/mem_msg_pkg.sv
`include "mem_msg_defines.svh"

package mem_msg_pkg;

   typedef enum logic
   {
      e_mem_read  = 1'b0,
      e_mem_write = 1'b1
   } mem_op_e;

   // ========================================
   // Address word, decoded per region
   typedef struct packed
   {
      logic                                          region;
      logic [`MEM_ADDR_W-`DRAM_IDX_W-4:0]             unused;
      logic [`DRAM_IDX_W-1:0]                        word;
      logic [1:0]                                    byte_off;  // Ignored, memory is word addressed
   } dram_addr_s;

   typedef struct packed
   {
      logic                                          region;
      logic [`MEM_ADDR_W-`IO_DEV_W-`IO_REG_IDX_W-2:0] unused;
      logic [`IO_DEV_W-1:0]                          dev_id;
      logic [`IO_REG_IDX_W-1:0]                      reg_idx;
   } io_addr_s;

   typedef union packed
   {
      dram_addr_s dram;
      io_addr_s   io;
   } mem_addr_u;

   // ========================================
   // Command and response messages
   typedef struct packed
   {
      mem_op_e                op;
      mem_addr_u              addr;
      logic [`MEM_DATA_W-1:0] data;
      logic [`MEM_ID_W-1:0]   id;
   } mem_cmd_s;

   typedef struct packed
   {
      logic [`MEM_ID_W-1:0]   id;
      logic [`MEM_DATA_W-1:0] data;
      logic                   err;
   } mem_resp_s;

endpackage

// File: hw/dram_endpoint.sv
`timescale 1ns/1ps
`include "mem_msg_defines.svh"

module dram_endpoint
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  mem_msg_pkg::mem_cmd_s cmd_i,
   input  logic                  cmd_v_i,
   output mem_msg_pkg::mem_resp_s resp_o,
   output logic                  resp_v_o
);

   import mem_msg_pkg::*;

   logic [`MEM_DATA_W-1:0] mem_r [`DRAM_WORDS];

   mem_cmd_s  s1_cmd_r;
   logic      s1_v_r;
   mem_resp_s s2_resp_r;
   logic      s2_v_r;

   // ========================================
   // Stage valids
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         s1_v_r <= 1'b0;
         s2_v_r <= 1'b0;
      end
      else
      begin
         s1_v_r <= cmd_v_i;
         s2_v_r <= s1_v_r;
      end
   end

   // ========================================
   // Stage one: capture and write
   always_ff @(posedge clk_i)
   begin
      if (cmd_v_i)
         s1_cmd_r <= cmd_i;
      if (cmd_v_i && cmd_i.op == e_mem_write)
         mem_r[cmd_i.addr.dram.word] <= cmd_i.data;  // Lands before any later read samples it
   end

   // Stage two: read and respond
   always_ff @(posedge clk_i)
   begin
      if (s1_v_r)
      begin
         s2_resp_r.id   <= s1_cmd_r.id;
         s2_resp_r.data <= (s1_cmd_r.op == e_mem_write) ? '0 : mem_r[s1_cmd_r.addr.dram.word];
         s2_resp_r.err  <= 1'b0;
      end
   end

   assign resp_o   = s2_resp_r;
   assign resp_v_o = s2_v_r;

   // The merger ordering depends on these strobes being clean two cycles on
   a_stage_v_known: assert property (@(posedge clk_i) disable iff (rst_i)
      !$isunknown({s1_v_r, s2_v_r}));

endmodule

// File: hw/io_reg_endpoint.sv
`timescale 1ns/1ps
`include "mem_msg_defines.svh"

module io_reg_endpoint
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  mem_msg_pkg::mem_cmd_s cmd_i,
   input  logic                  cmd_v_i,
   output mem_msg_pkg::mem_resp_s resp_o,
   output logic                  resp_v_o
);

   import mem_msg_pkg::*;

   logic [`MEM_DATA_W-1:0] regs_r [`IO_REGS];

   logic      dev_hit;
   logic      is_write;
   mem_resp_s resp_r;
   logic      resp_v_r;

   assign dev_hit  = (cmd_i.addr.io.dev_id == `IO_DEV_ID);
   assign is_write = (cmd_i.op == e_mem_write);

   // ========================================
   // Register bank
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         regs_r   <= '{default: '0};
         resp_v_r <= 1'b0;
      end
      else
      begin
         resp_v_r <= cmd_v_i;
         if (cmd_v_i && dev_hit && is_write)
            regs_r[cmd_i.addr.io.reg_idx] <= cmd_i.data;
      end
   end

   // ========================================
   // Response, one cycle after the command
   always_ff @(posedge clk_i)
   begin
      if (cmd_v_i)
      begin
         resp_r.id  <= cmd_i.id;
         resp_r.err <= !dev_hit;  // Foreign device, bank left untouched
         if (dev_hit && !is_write)
            resp_r.data <= regs_r[cmd_i.addr.io.reg_idx];
         else
            resp_r.data <= '0;
      end
   end

   assign resp_o   = resp_r;
   assign resp_v_o = resp_v_r;

endmodule

// File: hw/resp_merger.sv
`timescale 1ns/1ps

module resp_merger
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  mem_msg_pkg::mem_resp_s dram_resp_i,
   input  logic                   dram_resp_v_i,
   input  mem_msg_pkg::mem_resp_s io_resp_i,
   input  logic                   io_resp_v_i,
   output mem_msg_pkg::mem_resp_s resp_o,
   output logic                   resp_v_o
);

   import mem_msg_pkg::*;

   mem_resp_s  q_r [2];
   logic [1:0] count_r;

   // Queue contents followed by this cycle's arrivals, oldest first
   mem_resp_s  fill_list [4];
   logic [2:0] fill_n;

   mem_resp_s  resp_r;
   logic       resp_v_r;

   // ========================================
   // Ordering
   always_comb
   begin
      fill_list[0] = q_r[0];
      fill_list[1] = q_r[1];
      fill_list[2] = '0;
      fill_list[3] = '0;
      fill_n       = {1'b0, count_r};
      if (dram_resp_v_i)
      begin
         fill_list[fill_n[1:0]] = dram_resp_i;  // DRAM was issued earlier on a tie
         fill_n                 = fill_n + 3'd1;
      end
      if (io_resp_v_i)
      begin
         fill_list[fill_n[1:0]] = io_resp_i;
         fill_n                 = fill_n + 3'd1;
      end
   end

   // ========================================
   // Pop head into the output, keep the rest
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         count_r  <= 2'd0;
         resp_v_r <= 1'b0;
      end
      else
      begin
         resp_v_r <= (fill_n != 3'd0);
         count_r  <= (fill_n == 3'd0) ? 2'd0 : 2'(fill_n - 3'd1);
      end
   end

   always_ff @(posedge clk_i)
   begin
      resp_r <= fill_list[0];
      q_r[0] <= fill_list[1];
      q_r[1] <= fill_list[2];
   end

   assign resp_o   = resp_r;
   assign resp_v_o = resp_v_r;

   a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
      fill_n <= 3'd3);

   // Host keeps ids unique among commands in flight
   a_distinct_ids: assert property (@(posedge clk_i) disable iff (rst_i)
      (dram_resp_v_i && io_resp_v_i) |-> (dram_resp_i.id != io_resp_i.id));

endmodule

// File: hw/mem_msg_wrapper.sv
`timescale 1ns/1ps
`include "mem_msg_defines.svh"

module mem_msg_wrapper
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  mem_msg_pkg::mem_cmd_s  cmd_i,
   input  logic                   cmd_v_i,
   output mem_msg_pkg::mem_resp_s resp_o,
   output logic                   resp_v_o
);

   import mem_msg_pkg::*;

   logic      dram_cmd_v;
   logic      io_cmd_v;
   mem_resp_s dram_resp;
   logic      dram_resp_v;
   mem_resp_s io_resp;
   logic      io_resp_v;

   // ========================================
   // Region steering
   assign dram_cmd_v = cmd_v_i & ~cmd_i.addr[`MEM_REGION_BIT];
   assign io_cmd_v   = cmd_v_i &  cmd_i.addr[`MEM_REGION_BIT];

   // ========================================
   // Endpoints and merge
   dram_endpoint dram_ep
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .cmd_i    (cmd_i),
      .cmd_v_i  (dram_cmd_v),
      .resp_o   (dram_resp),
      .resp_v_o (dram_resp_v)
   );

   io_reg_endpoint io_ep
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .cmd_i    (cmd_i),
      .cmd_v_i  (io_cmd_v),
      .resp_o   (io_resp),
      .resp_v_o (io_resp_v)
   );

   resp_merger merger
   (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .dram_resp_i   (dram_resp),
      .dram_resp_v_i (dram_resp_v),
      .io_resp_i     (io_resp),
      .io_resp_v_i   (io_resp_v),
      .resp_o        (resp_o),
      .resp_v_o      (resp_v_o)
   );

endmodule

// File: verification/tb_mem_msg_wrapper.sv
`timescale 1ns/1ps
`include "mem_msg_defines.svh"

module tb_mem_msg_wrapper;

   import mem_msg_pkg::*;

   localparam int MAX_CMDS = 64;
   localparam int COLS     = 7;
   localparam int NO_GAP   = 4;  // Group that is issued back to back

   logic      clk_i = 1'b0;
   logic      rst_i;
   mem_cmd_s  cmd_i;
   logic      cmd_v_i;
   mem_resp_s resp_o;
   logic      resp_v_o;

   logic [31:0] td [0:MAX_CMDS*COLS-1];
   mem_resp_s   exp_q [$];
   mem_resp_s   sb_head;
   int          n_cmds     = 0;
   int          wd_cycles  = 0;
   int          responses  = 0;
   int          checks     = 0;
   int          errors     = 0;

   mem_msg_wrapper dut
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .cmd_i    (cmd_i),
      .cmd_v_i  (cmd_v_i),
      .resp_o   (resp_o),
      .resp_v_o (resp_v_o)
   );

   always #2 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic drive_command(input int idx);
      mem_cmd_s  cmd;
      mem_resp_s exp;
      int        b;
      b        = idx * COLS;
      cmd.op   = td[b + 1][0] ? e_mem_write : e_mem_read;
      cmd.addr = td[b + 2][`MEM_ADDR_W-1:0];
      cmd.data = td[b + 3];
      cmd.id   = td[b + 4][`MEM_ID_W-1:0];
      exp.id   = cmd.id;
      exp.data = td[b + 5];
      exp.err  = td[b + 6][0];
      @(negedge clk_i);
      exp_q.push_back(exp);
      cmd_i   = cmd;
      cmd_v_i = 1'b1;
   endtask

   task automatic idle_bus();
      @(negedge clk_i);
      cmd_v_i = 1'b0;
   endtask

   task automatic drain_responses();
      if (cmd_v_i)
         idle_bus();
      while (exp_q.size() != 0)
         @(negedge clk_i);
   endtask

   // ========================================
   // Scoreboard, sampled between edges
   always @(negedge clk_i)
   begin
      #1;
      if (!rst_i && resp_v_o)
      begin
         responses++;
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("Response with id %h arrived while no command was outstanding", resp_o.id);
         end
         else
         begin
            sb_head = exp_q.pop_front();
            check_value("resp_o.id", 32'(resp_o.id), 32'(sb_head.id));
            check_value("resp_o.data", resp_o.data, sb_head.data);
            check_value("resp_o.err", 32'(resp_o.err), 32'(sb_head.err));
         end
      end
   end

   // ========================================
   // Stimulus
   initial
   begin
      int          i;
      int          grp;
      int          grp_n;
      int          grp_err;
      int          gap;
      logic [31:0] seed;
      seed    = 32'h5bae_f6ab;
      rst_i   = 1'b1;
      cmd_i   = '0;
      cmd_v_i = 1'b0;
      for (i = 0; i < MAX_CMDS * COLS; i++)
         td[i] = 32'hffff_ffff;  // End marker where the file stops
      $readmemh("verification/mem_msg_testdata.txt", td);
      while (n_cmds < MAX_CMDS && td[n_cmds * COLS] != 32'hffff_ffff)
         n_cmds++;
      wd_cycles = n_cmds * 6 + 50;
      if (n_cmds == 0)
      begin
         errors++;
         $display("No commands were read from the data file");
      end
      repeat (5) @(negedge clk_i);
      rst_i = 1'b0;
      i = 0;
      while (i < n_cmds)
      begin
         grp     = int'(td[i * COLS]);
         grp_n   = 0;
         grp_err = errors;
         while (i < n_cmds && int'(td[i * COLS]) == grp)
         begin
            drive_command(i);
            grp_n++;
            i++;
            seed = lcg_next(seed);
            gap  = (grp == NO_GAP) ? 0 : int'(seed[31:16] % 16'd3);
            if (gap > 0)
            begin
               idle_bus();
               repeat (gap - 1) @(negedge clk_i);
            end
         end
         drain_responses();
         $display("test group %0d done: %0d commands, %0d errors", grp, grp_n,
                  errors - grp_err);
      end
      repeat (10) @(negedge clk_i);  // Window for stray responses
      if (responses != n_cmds)
      begin
         errors++;
         $display("Saw %0d responses for %0d commands", responses, n_cmds);
      end
      $display("summary: %0d commands, %0d responses, %0d checks, %0d errors",
               n_cmds, responses, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // ========================================
   // Watchdog
   initial
   begin
      wait (wd_cycles != 0);
      #(wd_cycles * 4);
      $display("Run did not finish within %0d cycles, responses are missing", wd_cycles);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: flist.f
+incdir+hw
hw/mem_msg_pkg.sv
hw/dram_endpoint.sv
hw/io_reg_endpoint.sv
hw/resp_merger.sv
hw/mem_msg_wrapper.sv
verification/tb_mem_msg_wrapper.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
   --top-module tb_mem_msg_wrapper -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_msg_wrapper)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
else
   exit 1
fi

// File: verification/mem_msg_testdata.txt
// Columns: group op addr wdata id exp_data exp_err (all hex, op 1 is a write)
// DRAM word index sits in addr[7:2], I/O device id in addr[6:3] and register in addr[2:0]
// Group 1: DRAM write then read back
1 1 000c 1234abcd 1 0        0
1 0 000c 0        2 1234abcd 0
1 1 00fc cafef00d 3 0        0
1 1 0010 0badc0de 4 0        0
1 0 00fc 0        5 cafef00d 0
1 0 0010 0        6 0badc0de 0
1 1 0013 55aa55aa 7 0        0
1 0 0011 0        8 55aa55aa 0
// Group 2: I/O registers of device 5
2 0 802a 0        9 0        0
2 1 802a 89abcdef a 0        0
2 0 802a 0        b 89abcdef 0
2 1 802f 13579bdf c 0        0
2 0 802f 0        d 13579bdf 0
2 0 8028 0        e 0        0
// Group 3: foreign device ids leave the bank alone
3 1 801a deadbeef f 0        1
3 0 801a 0        0 0        1
3 0 802a 0        1 89abcdef 0
3 1 807a 11111111 2 0        1
3 0 802a 0        3 89abcdef 0
// Group 4: back to back mixed traffic, issued with no gap
4 1 0020 a5a5a5a5 4 0        0
4 0 802a 0        5 89abcdef 0
4 0 0020 0        6 a5a5a5a5 0
4 1 802b 0f0f0f0f 7 0        0
4 0 802b 0        8 0f0f0f0f 0
4 0 0020 0        9 a5a5a5a5 0
4 0 801b 0        a 0        1
4 1 0024 77777777 b 0        0
4 0 0024 0        c 77777777 0
4 0 802b 0        d 0f0f0f0f 0
